//--- Makefile
VERILATOR ?= verilator
TOP       ?= microrocDaqTb
FILELIST  ?= microrocDaqTop.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- hdl/commandRegisters.sv
`timescale 1ns/1ps

module commandRegisters (
    input  logic                                clk,
    input  logic                                rstN,
    // Wishbone classic slave
    input  logic [microrocPkg::WbAddrWidth-1:0] wbAdr,
    input  logic [microrocPkg::DataWidth-1:0]   wbDatI,
    output logic [microrocPkg::DataWidth-1:0]   wbDatO,
    input  logic                                wbWe,
    input  logic                                wbStb,
    input  logic                                wbCyc,
    output logic                                wbAck,
    // Run control
    output microrocPkg::modeT                   mode,
    output logic                                run,
    output logic                                scOrReadreg,
    microrocScIf.source                         usbSc,
    // Sweep setup
    output logic [microrocPkg::DacWidth-1:0]    sweepStart,
    output logic [microrocPkg::DacWidth-1:0]    sweepStop,
    output logic [microrocPkg::DacWidth-1:0]    sweepStep,
    output logic [microrocPkg::DataWidth-1:0]   window,
    output logic                                sweepGo,
    input  logic                                busy
);
    import microrocPkg::*;

    logic                 reqNew;
    logic                 wrEn;
    logic                 busyQ;
    logic                 done;
    logic [DataWidth-1:0] readMux;

    // Fresh request, not yet acknowledged
    assign reqNew = wbCyc && wbStb && !wbAck;
    assign wrEn   = reqNew && wbWe;

    always_comb begin
        readMux = '0;
        case (wbAdr)
            RegControl: begin
                readMux[1:0]               = mode;
                readMux[CtrlRunBit]        = run;
                readMux[CtrlScOrReadregBit] = scOrReadreg;
            end
            RegDac0:       readMux[DacWidth-1:0] = usbSc.dac0;
            RegDac1:       readMux[DacWidth-1:0] = usbSc.dac1;
            RegDac2:       readMux[DacWidth-1:0] = usbSc.dac2;
            RegMask: begin
                readMux[ChanWidth-1:0]                     = usbSc.channelMask;
                readMux[ChanWidth+DiscriWidth-1:ChanWidth] = usbSc.discriMask;
            end
            RegCTest:      readMux[ChanWidth-1:0] = usbSc.cTestChannel;
            RegSweepStart: readMux[DacWidth-1:0] = sweepStart;
            RegSweepStop:  readMux[DacWidth-1:0] = sweepStop;
            RegSweepStep:  readMux[DacWidth-1:0] = sweepStep;
            RegWindow:     readMux = window;
            RegStatus: begin
                readMux[StatusBusyBit] = busy;
                readMux[StatusDoneBit] = done;
            end
            default:       readMux = '0;
        endcase
    end

    ////////////////////////////////////////
    // Register file and strobes
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbAck              <= 1'b0;
            mode               <= AcqMode;
            run                <= 1'b0;
            scOrReadreg        <= 1'b0;
            usbSc.dac0         <= '0;
            usbSc.dac1         <= '0;
            usbSc.dac2         <= '0;
            usbSc.channelMask  <= '0;
            usbSc.discriMask   <= '0;
            usbSc.cTestChannel <= '0;
            usbSc.scLoad       <= 1'b0;
            sweepStart         <= '0;
            sweepStop          <= '0;
            sweepStep          <= '0;
            window             <= '0;
            sweepGo            <= 1'b0;
            busyQ              <= 1'b0;
            done               <= 1'b0;
        end else begin
            wbAck        <= reqNew;
            usbSc.scLoad <= 1'b0;
            sweepGo      <= 1'b0;
            busyQ        <= busy;
            // Falling busy marks the end of a sweep
            if (busyQ && !busy) begin
                done <= 1'b1;
            end
            if (sweepGo) begin
                done <= 1'b0;
            end
            if (wrEn) begin
                case (wbAdr)
                    RegControl: begin
                        mode        <= modeT'(wbDatI[1:0]);
                        run         <= wbDatI[CtrlRunBit];
                        scOrReadreg <= wbDatI[CtrlScOrReadregBit];
                        sweepGo     <= wbDatI[CtrlRunBit] &&
                                       (wbDatI[1:0] == SCurveMode ||
                                        wbDatI[1:0] == SweepAcqMode);
                    end
                    RegDac0:       usbSc.dac0 <= wbDatI[DacWidth-1:0];
                    RegDac1:       usbSc.dac1 <= wbDatI[DacWidth-1:0];
                    RegDac2:       usbSc.dac2 <= wbDatI[DacWidth-1:0];
                    RegMask: begin
                        usbSc.channelMask <= wbDatI[ChanWidth-1:0];
                        usbSc.discriMask  <= wbDatI[ChanWidth+DiscriWidth-1:ChanWidth];
                    end
                    RegCTest:      usbSc.cTestChannel <= wbDatI[ChanWidth-1:0];
                    RegSweepStart: sweepStart <= wbDatI[DacWidth-1:0];
                    RegSweepStop:  sweepStop <= wbDatI[DacWidth-1:0];
                    RegSweepStep:  sweepStep <= wbDatI[DacWidth-1:0];
                    RegWindow:     window <= wbDatI;
                    RegScLoad:     usbSc.scLoad <= 1'b1;
                    default:       ;
                endcase
            end
        end
    end

    // Read data lands together with the ack
    always_ff @(posedge clk) begin
        if (reqNew) begin
            wbDatO <= readMux;
        end
    end

    ackOnlyOnRequest: assert property (@(posedge clk) disable iff (!rstN)
        $rose(wbAck) |-> $past(wbCyc && wbStb));

endmodule

//--- hdl/microrocDaqTop.sv
`timescale 1ns/1ps

module microrocDaqTop (
    input  logic                                clk,
    input  logic                                rstN,
    // Host Wishbone port
    input  logic [microrocPkg::WbAddrWidth-1:0] wbAdr,
    input  logic [microrocPkg::DataWidth-1:0]   wbDatI,
    output logic [microrocPkg::DataWidth-1:0]   wbDatO,
    input  logic                                wbWe,
    input  logic                                wbStb,
    input  logic                                wbCyc,
    output logic                                wbAck,
    // ASIC and USB side
    input  logic                                trigger,
    input  logic [microrocPkg::DataWidth-1:0]   microrocAcqData,
    input  logic                                microrocAcqDataEn,
    input  logic                                usbFifoFull,
    output logic [microrocPkg::DacWidth-1:0]    outDac0,
    output logic [microrocPkg::DacWidth-1:0]    outDac1,
    output logic [microrocPkg::DacWidth-1:0]    outDac2,
    output logic [microrocPkg::ChanWidth-1:0]   outChannelMask,
    output logic [microrocPkg::DiscriWidth-1:0] outDiscriMask,
    output logic [microrocPkg::ChanWidth-1:0]   outCTestChannel,
    output logic                                outScLoad,
    output logic                                outScOrReadreg,
    output logic                                usbStartStop,
    output logic                                microrocAcqStartStop,
    output logic [microrocPkg::DataWidth-1:0]   usbFifoData,
    output logic                                usbFifoDataEn,
    output logic [microrocPkg::DataWidth-1:0]   parallelData,
    output logic                                parallelDataEn
);
    import microrocPkg::*;

    modeT                 mode;
    logic                 run;
    logic                 scOrReadreg;
    logic [DacWidth-1:0]  sweepStart;
    logic [DacWidth-1:0]  sweepStop;
    logic [DacWidth-1:0]  sweepStep;
    logic [DataWidth-1:0] window;
    logic                 sweepGo;
    logic                 busy;
    logic [DacWidth-1:0]  sweepDac0;
    logic                 sweepScLoad;
    logic                 sweepAcqStartStop;
    logic [DataWidth-1:0] sweepData;
    logic                 sweepDataEn;

    // Host slow-control set
    microrocScIf usbScIf ();

    commandRegisters cmdRegs0 (
        .clk, .rstN, .wbAdr, .wbDatI, .wbDatO, .wbWe, .wbStb, .wbCyc, .wbAck,
        .mode, .run, .scOrReadreg,
        .usbSc      (usbScIf.source),
        .sweepStart, .sweepStop, .sweepStep, .window, .sweepGo, .busy
    );

    sweepController sweep0 (
        .clk, .rstN, .mode, .sweepGo,
        .sweepStart, .sweepStop, .sweepStep, .window,
        .trigger, .usbFifoFull,
        .sweepDac0, .sweepScLoad, .sweepAcqStartStop,
        .sweepData, .sweepDataEn, .busy
    );

    modeSwitcher switcher0 (
        .mode, .run, .scOrReadreg, .busy,
        .usbSc      (usbScIf.sink),
        .sweepDac0, .sweepScLoad, .sweepAcqStartStop, .sweepData, .sweepDataEn,
        .microrocAcqData, .microrocAcqDataEn,
        .outDac0, .outDac1, .outDac2,
        .outChannelMask, .outDiscriMask, .outCTestChannel,
        .outScLoad, .outScOrReadreg,
        .usbStartStop, .microrocAcqStartStop,
        .usbFifoData, .usbFifoDataEn, .parallelData, .parallelDataEn
    );

endmodule

//--- hdl/microrocPkg.sv
package microrocPkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int DacWidth    = 10;
    localparam int DataWidth   = 16;
    localparam int WbAddrWidth = 4;
    localparam int ChanWidth   = 7;
    localparam int DiscriWidth = 2;

    // Cycles from a load pulse to the window
    localparam int SettleCycles = 4;

    // Top bits of a header word, above the DAC value
    localparam logic [DataWidth-DacWidth-1:0] HeaderMarker = 6'b101010;

    ////////////////////////////////////////
    // Register map
    ////////////////////////////////////////
    localparam logic [WbAddrWidth-1:0] RegControl    = 4'd0;
    localparam logic [WbAddrWidth-1:0] RegDac0       = 4'd1;
    localparam logic [WbAddrWidth-1:0] RegDac1       = 4'd2;
    localparam logic [WbAddrWidth-1:0] RegDac2       = 4'd3;
    localparam logic [WbAddrWidth-1:0] RegMask       = 4'd4;
    localparam logic [WbAddrWidth-1:0] RegCTest      = 4'd5;
    localparam logic [WbAddrWidth-1:0] RegSweepStart = 4'd6;
    localparam logic [WbAddrWidth-1:0] RegSweepStop  = 4'd7;
    localparam logic [WbAddrWidth-1:0] RegSweepStep  = 4'd8;
    localparam logic [WbAddrWidth-1:0] RegWindow     = 4'd9;
    localparam logic [WbAddrWidth-1:0] RegStatus     = 4'd10;
    localparam logic [WbAddrWidth-1:0] RegScLoad     = 4'd11;

    // Bit positions in control and status words
    localparam int CtrlRunBit         = 2;
    localparam int CtrlScOrReadregBit = 3;
    localparam int StatusBusyBit      = 0;
    localparam int StatusDoneBit      = 1;

    typedef enum logic [1:0] {
        AcqMode      = 2'd0,
        SCurveMode   = 2'd1,
        SweepAcqMode = 2'd2,
        NoneMode     = 2'd3
    } modeT;

    typedef enum logic [2:0] {
        Idle, Load, Settle, Window, Header, Count, Next
    } sweepStateT;

endpackage

//--- hdl/microrocScIf.sv
`timescale 1ns/1ps

interface microrocScIf;
    import microrocPkg::*;

    logic [DacWidth-1:0]    dac0;
    logic [DacWidth-1:0]    dac1;
    logic [DacWidth-1:0]    dac2;
    logic [ChanWidth-1:0]   channelMask;
    logic [DiscriWidth-1:0] discriMask;
    logic [ChanWidth-1:0]   cTestChannel;
    // One-cycle parameter load strobe
    logic                   scLoad;

    // Register file side
    modport source (
        output dac0, dac1, dac2, channelMask, discriMask, cTestChannel, scLoad
    );

    // Mode switcher side
    modport sink (
        input dac0, dac1, dac2, channelMask, discriMask, cTestChannel, scLoad
    );

endinterface

//--- hdl/modeSwitcher.sv
`timescale 1ns/1ps

module modeSwitcher (
    input  microrocPkg::modeT                   mode,
    input  logic                                run,
    input  logic                                scOrReadreg,
    input  logic                                busy,
    microrocScIf.sink                           usbSc,
    // Sweep controller side
    input  logic [microrocPkg::DacWidth-1:0]    sweepDac0,
    input  logic                                sweepScLoad,
    input  logic                                sweepAcqStartStop,
    input  logic [microrocPkg::DataWidth-1:0]   sweepData,
    input  logic                                sweepDataEn,
    // ASIC readout
    input  logic [microrocPkg::DataWidth-1:0]   microrocAcqData,
    input  logic                                microrocAcqDataEn,
    // Slow control towards the ASIC
    output logic [microrocPkg::DacWidth-1:0]    outDac0,
    output logic [microrocPkg::DacWidth-1:0]    outDac1,
    output logic [microrocPkg::DacWidth-1:0]    outDac2,
    output logic [microrocPkg::ChanWidth-1:0]   outChannelMask,
    output logic [microrocPkg::DiscriWidth-1:0] outDiscriMask,
    output logic [microrocPkg::ChanWidth-1:0]   outCTestChannel,
    output logic                                outScLoad,
    output logic                                outScOrReadreg,
    // Start/stop and data streams
    output logic                                usbStartStop,
    output logic                                microrocAcqStartStop,
    output logic [microrocPkg::DataWidth-1:0]   usbFifoData,
    output logic                                usbFifoDataEn,
    output logic [microrocPkg::DataWidth-1:0]   parallelData,
    output logic                                parallelDataEn
);
    import microrocPkg::*;

    always_comb begin
        // Host-driven routing, the base for every mode
        outDac0              = usbSc.dac0;
        outDac1              = usbSc.dac1;
        outDac2              = usbSc.dac2;
        outChannelMask       = usbSc.channelMask;
        outDiscriMask        = usbSc.discriMask;
        outCTestChannel      = usbSc.cTestChannel;
        outScLoad            = usbSc.scLoad;
        outScOrReadreg       = scOrReadreg;
        usbStartStop         = run;
        microrocAcqStartStop = run;
        usbFifoData          = microrocAcqData;
        usbFifoDataEn        = microrocAcqDataEn;
        parallelData         = '0;
        parallelDataEn       = 1'b0;
        case (mode)
            AcqMode, NoneMode: ;
            SCurveMode, SweepAcqMode: begin
                // Sweep owns DAC0 and the load strobe
                outDac0              = sweepDac0;
                outScLoad            = sweepScLoad;
                outScOrReadreg       = 1'b0;
                usbStartStop         = busy;
                microrocAcqStartStop = 1'b0;
                usbFifoData          = sweepData;
                usbFifoDataEn        = sweepDataEn;
                if (mode == SweepAcqMode) begin
                    microrocAcqStartStop = sweepAcqStartStop;
                    parallelData         = microrocAcqData;
                    parallelDataEn       = microrocAcqDataEn;
                end
            end
            default: ;
        endcase
        parallelOnlyInSweepAcq: assert (!parallelDataEn || mode == SweepAcqMode);
    end

endmodule

//--- hdl/sweepController.sv
`timescale 1ns/1ps

module sweepController (
    input  logic                              clk,
    input  logic                              rstN,
    input  microrocPkg::modeT                 mode,
    input  logic                              sweepGo,
    input  logic [microrocPkg::DacWidth-1:0]  sweepStart,
    input  logic [microrocPkg::DacWidth-1:0]  sweepStop,
    input  logic [microrocPkg::DacWidth-1:0]  sweepStep,
    input  logic [microrocPkg::DataWidth-1:0] window,
    input  logic                              trigger,
    input  logic                              usbFifoFull,
    output logic [microrocPkg::DacWidth-1:0]  sweepDac0,
    output logic                              sweepScLoad,
    output logic                              sweepAcqStartStop,
    output logic [microrocPkg::DataWidth-1:0] sweepData,
    output logic                              sweepDataEn,
    output logic                              busy
);
    import microrocPkg::*;

    sweepStateT           state;
    modeT                 modeQ;
    logic [DataWidth-1:0] cycleCnt;
    logic [DataWidth-1:0] trigCount;
    logic [DacWidth-1:0]  stepEff;
    logic [DacWidth:0]    nextDac;
    logic                 wordState;

    // A zero step would never finish
    assign stepEff = (sweepStep == '0) ? DacWidth'(1) : sweepStep;
    // Extra bit catches 10-bit overflow
    assign nextDac = {1'b0, sweepDac0} + {1'b0, stepEff};

    assign busy              = (state != Idle);
    assign sweepAcqStartStop = (state == Window) && (modeQ == SweepAcqMode);
    assign wordState         = (state == Header) || (state == Count);
    assign sweepDataEn       = wordState && !usbFifoFull;
    assign sweepData         = (state == Count) ? trigCount : {HeaderMarker, sweepDac0};

    ////////////////////////////////////////
    // Step sequencer
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state       <= Idle;
            modeQ       <= AcqMode;
            sweepDac0   <= '0;
            sweepScLoad <= 1'b0;
            cycleCnt    <= '0;
            trigCount   <= '0;
        end else begin
            sweepScLoad <= 1'b0;
            case (state)
                Idle: begin
                    if (sweepGo) begin
                        modeQ       <= mode;
                        sweepDac0   <= sweepStart;
                        sweepScLoad <= 1'b1;
                        state       <= Load;
                    end
                end
                Load: begin
                    cycleCnt  <= '0;
                    trigCount <= '0;
                    state     <= Settle;
                end
                Settle: begin
                    if (cycleCnt == DataWidth'(SettleCycles - 1)) begin
                        cycleCnt <= '0;
                        state    <= Window;
                    end else begin
                        cycleCnt <= cycleCnt + 1'b1;
                    end
                end
                Window: begin
                    // Saturating trigger count
                    if (modeQ == SCurveMode && trigger && trigCount != '1) begin
                        trigCount <= trigCount + 1'b1;
                    end
                    if (cycleCnt + 1 >= window) begin
                        state <= Header;
                    end else begin
                        cycleCnt <= cycleCnt + 1'b1;
                    end
                end
                Header: begin
                    if (!usbFifoFull) begin
                        if (modeQ == SCurveMode) begin
                            state <= Count;
                        end else begin
                            state <= Next;
                        end
                    end
                end
                Count: begin
                    if (!usbFifoFull) begin
                        state <= Next;
                    end
                end
                Next: begin
                    if (nextDac > {1'b0, sweepStop}) begin
                        state <= Idle;
                    end else begin
                        sweepDac0   <= nextDac[DacWidth-1:0];
                        sweepScLoad <= 1'b1;
                        state       <= Load;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    // A blocked word waits unchanged for the FIFO
    holdWordWhileFull: assert property (@(posedge clk) disable iff (!rstN)
        wordState && usbFifoFull |=> $stable(state) && $stable(sweepData));

    loadOnlyInLoad: assert property (@(posedge clk) disable iff (!rstN)
        sweepScLoad |-> state == Load);

endmodule

//--- microrocDaqTop.f
hdl/microrocPkg.sv
hdl/microrocScIf.sv
hdl/commandRegisters.sv
hdl/sweepController.sv
hdl/modeSwitcher.sv
hdl/microrocDaqTop.sv
test/microrocDaqTb.sv

//--- test/microrocDaqTb.sv
`timescale 1ns/1ps

module microrocDaqTb;
    import microrocPkg::*;

    localparam int SweepSteps    = 3;
    localparam int WindowLen     = 8;
    localparam logic [9:0] TriggerDac = 10'd20;
    // Cycles of one sweep without back-pressure
    localparam int SweepCycles   = SweepSteps * (WindowLen + SettleCycles + 4);
    localparam int TimeoutCycles = 8 * SweepCycles + 1000;
    localparam int AckLimit      = 16;

    logic                   clk;
    logic                   rstN;
    logic [WbAddrWidth-1:0] wbAdr;
    logic [DataWidth-1:0]   wbDatI;
    logic [DataWidth-1:0]   wbDatO;
    logic                   wbWe;
    logic                   wbStb;
    logic                   wbCyc;
    logic                   wbAck;
    logic                   trigger;
    logic [DataWidth-1:0]   microrocAcqData;
    logic                   microrocAcqDataEn;
    logic                   usbFifoFull;
    logic [DacWidth-1:0]    outDac0;
    logic [DacWidth-1:0]    outDac1;
    logic [DacWidth-1:0]    outDac2;
    logic [ChanWidth-1:0]   outChannelMask;
    logic [DiscriWidth-1:0] outDiscriMask;
    logic [ChanWidth-1:0]   outCTestChannel;
    logic                   outScLoad;
    logic                   outScOrReadreg;
    logic                   usbStartStop;
    logic                   microrocAcqStartStop;
    logic [DataWidth-1:0]   usbFifoData;
    logic                   usbFifoDataEn;
    logic [DataWidth-1:0]   parallelData;
    logic                   parallelDataEn;

    integer               seed = 32'hb652;
    int                   errors = 0;
    int                   cycles = 0;
    int                   scLoadCount = 0;
    logic [DataWidth-1:0] usbQ[$];
    logic [DataWidth-1:0] parQ[$];
    logic [DataWidth-1:0] expUsb[$];
    logic [DataWidth-1:0] expPar[$];
    logic [9:0]           dac0Val;
    logic [9:0]           dac1Val;
    logic [9:0]           dac2Val;
    logic [8:0]           maskVal;
    logic [6:0]           cTestVal;
    logic [15:0]          rdData;

    microrocDaqTop dut0 (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    ////////////////////////////////////////
    // Monitors and run limit
    ////////////////////////////////////////
    always @(posedge clk) begin
        if (usbFifoDataEn) begin
            usbQ.push_back(usbFifoData);
            checkValue(usbFifoFull, 0, "USB word sent while FIFO full");
        end
        if (parallelDataEn) begin
            parQ.push_back(parallelData);
        end
        if (outScLoad) begin
            scLoadCount++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TimeoutCycles) begin
            $display("Timeout after %0d cycles, the run hung (%0d errors)", cycles, errors);
            $display("tests failed");
            $finish;
        end
    end

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
        end
    endtask

    // Header word is the marker above the DAC value
    function automatic logic [15:0] headerWord(input logic [9:0] dac);
        return {6'b101010, dac};
    endfunction

    function automatic logic [15:0] controlWord(input logic [1:0] m, input bit runBit,
                                                input bit scBit);
        return {12'b0, scBit, runBit, m};
    endfunction

    ////////////////////////////////////////
    // Wishbone driver
    ////////////////////////////////////////
    task automatic wbAccess(input bit we, input logic [WbAddrWidth-1:0] adr,
                            input logic [15:0] dataIn, output logic [15:0] dataOut);
        int n;
        @(posedge clk);
        #1;
        wbAdr  = adr;
        wbDatI = dataIn;
        wbWe   = we;
        wbStb  = 1'b1;
        wbCyc  = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!wbAck && n < AckLimit);
        if (!wbAck) begin
            errors++;
            $display("No Wishbone ack at %0t ns for address %0d", $time, adr);
        end
        dataOut = wbDatO;
        wbStb   = 1'b0;
        wbCyc   = 1'b0;
        wbWe    = 1'b0;
    endtask

    task automatic wbWrite(input logic [WbAddrWidth-1:0] adr, input logic [15:0] data);
        logic [15:0] unused;
        wbAccess(1'b1, adr, data, unused);
    endtask

    task automatic wbRead(input logic [WbAddrWidth-1:0] adr, output logic [15:0] data);
        wbAccess(1'b0, adr, 16'h0000, data);
    endtask

    task automatic clearStreams();
        usbQ.delete();
        parQ.delete();
        expUsb.delete();
        expPar.delete();
    endtask

    task automatic checkStreams(input string name);
        checkValue(usbQ.size(), expUsb.size(), $sformatf("%s: USB word count", name));
        foreach (expUsb[i]) begin
            if (i < usbQ.size()) begin
                checkValue(usbQ[i], expUsb[i], $sformatf("%s: USB word %0d", name, i));
            end
        end
        checkValue(parQ.size(), expPar.size(), $sformatf("%s: parallel word count", name));
        foreach (expPar[i]) begin
            if (i < parQ.size()) begin
                checkValue(parQ[i], expPar[i], $sformatf("%s: parallel word %0d", name, i));
            end
        end
    endtask

    task automatic driveAsicWords(input int count);
        logic [31:0] rnd;
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            #1;
            rnd = $random(seed);
            microrocAcqData   = rnd[15:0];
            microrocAcqDataEn = 1'b1;
            expUsb.push_back(rnd[15:0]);
        end
        @(posedge clk);
        #1;
        microrocAcqDataEn = 1'b0;
    endtask

    // Starts a sweep and follows it until busy has risen and fallen
    task automatic runSweep(input logic [15:0] ctrl, input bit randomFull, input bit trigOn,
                            input bit driveAsic);
        int n;
        bit sawBusy;
        logic [31:0] rnd;
        wbWrite(RegControl, ctrl);
        n = 0;
        sawBusy = 1'b0;
        while (!(sawBusy && !usbStartStop) && n < 4 * SweepCycles + 50) begin
            @(posedge clk);
            #1;
            n++;
            if (usbStartStop) begin
                sawBusy = 1'b1;
            end
            rnd = $random(seed);
            usbFifoFull = randomFull && rnd[0];
            trigger     = trigOn && (outDac0 == TriggerDac);
            if (driveAsic && microrocAcqStartStop) begin
                microrocAcqData   = rnd[31:16];
                microrocAcqDataEn = 1'b1;
                expPar.push_back(rnd[31:16]);
            end else begin
                microrocAcqDataEn = 1'b0;
            end
        end
        if (!(sawBusy && !usbStartStop)) begin
            errors++;
            $display("Sweep did not finish within %0d cycles", n);
        end
        usbFifoFull       = 1'b0;
        trigger           = 1'b0;
        microrocAcqDataEn = 1'b0;
    endtask

    task automatic setupSweep();
        wbWrite(RegSweepStart, 16'd10);
        wbWrite(RegSweepStop, 16'd30);
        wbWrite(RegSweepStep, 16'd10);
        wbWrite(RegWindow, 16'(WindowLen));
    endtask

    // Trigger held high on the second step only
    task automatic expectSCurveWords();
        expUsb.push_back(headerWord(10'd10));
        expUsb.push_back(16'd0);
        expUsb.push_back(headerWord(10'd20));
        expUsb.push_back(16'd8);
        expUsb.push_back(headerWord(10'd30));
        expUsb.push_back(16'd0);
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    task automatic testRegisters();
        logic [31:0] rnd;
        checkValue(usbStartStop, 0, "usbStartStop after reset");
        checkValue(microrocAcqStartStop, 0, "microrocAcqStartStop after reset");
        rnd = $random(seed);
        dac0Val = rnd[9:0];
        dac1Val = rnd[19:10];
        dac2Val = rnd[29:20];
        rnd = $random(seed);
        maskVal  = rnd[8:0];
        cTestVal = rnd[15:9];
        wbWrite(RegDac0, {6'b0, dac0Val});
        wbWrite(RegDac1, {6'b0, dac1Val});
        wbWrite(RegDac2, {6'b0, dac2Val});
        wbWrite(RegMask, {7'b0, maskVal});
        wbWrite(RegCTest, {9'b0, cTestVal});
        wbRead(RegDac0, rdData);
        checkValue(rdData, {6'b0, dac0Val}, "DAC0 readback");
        wbRead(RegDac1, rdData);
        checkValue(rdData, {6'b0, dac1Val}, "DAC1 readback");
        wbRead(RegDac2, rdData);
        checkValue(rdData, {6'b0, dac2Val}, "DAC2 readback");
        wbRead(RegMask, rdData);
        checkValue(rdData, {7'b0, maskVal}, "mask readback");
        wbRead(RegCTest, rdData);
        checkValue(rdData, {9'b0, cTestVal}, "CTest readback");
        checkValue(outDac0, dac0Val, "ACQ outDac0");
        checkValue(outDac1, dac1Val, "ACQ outDac1");
        checkValue(outDac2, dac2Val, "ACQ outDac2");
        checkValue(outChannelMask, maskVal[6:0], "ACQ outChannelMask");
        checkValue(outDiscriMask, maskVal[8:7], "ACQ outDiscriMask");
        checkValue(outCTestChannel, cTestVal, "ACQ outCTestChannel");
        scLoadCount = 0;
        wbWrite(RegScLoad, 16'h0001);
        repeat (3) @(posedge clk);
        #1;
        checkValue(scLoadCount, 1, "outScLoad pulses for one load write");
    endtask

    task automatic testAcqPath();
        wbWrite(RegControl, controlWord(2'd0, 1'b1, 1'b0));
        checkValue(microrocAcqStartStop, 1, "ACQ microrocAcqStartStop with run");
        checkValue(usbStartStop, 1, "ACQ usbStartStop with run");
        clearStreams();
        driveAsicWords(8);
        checkStreams("ACQ data path");
        wbWrite(RegControl, controlWord(2'd0, 1'b0, 1'b0));
        checkValue(usbStartStop, 0, "ACQ usbStartStop after stop");
    endtask

    task automatic testSCurve();
        setupSweep();
        clearStreams();
        expectSCurveWords();
        runSweep(controlWord(2'd1, 1'b1, 1'b1), 1'b0, 1'b1, 1'b0);
        checkValue(outScOrReadreg, 0, "SCurve forces outScOrReadreg low");
        checkStreams("SCurve sweep");
        wbRead(RegStatus, rdData);
        checkValue(rdData, 16'h0002, "status after SCurve sweep");
    endtask

    task automatic testBackPressure();
        clearStreams();
        expectSCurveWords();
        runSweep(controlWord(2'd1, 1'b1, 1'b1), 1'b1, 1'b1, 1'b0);
        checkStreams("SCurve with back-pressure");
        wbRead(RegStatus, rdData);
        checkValue(rdData, 16'h0002, "status after back-pressure sweep");
    endtask

    task automatic testSweepAcq();
        clearStreams();
        expUsb.push_back(headerWord(10'd10));
        expUsb.push_back(headerWord(10'd20));
        expUsb.push_back(headerWord(10'd30));
        runSweep(controlWord(2'd2, 1'b1, 1'b0), 1'b0, 1'b0, 1'b1);
        checkValue(expPar.size(), SweepSteps * WindowLen, "ASIC words sent in windows");
        checkStreams("SweepACQ");
        checkValue(outDac1, dac1Val, "SweepACQ outDac1");
        checkValue(outDac2, dac2Val, "SweepACQ outDac2");
        wbRead(RegStatus, rdData);
        checkValue(rdData, 16'h0002, "status after SweepACQ");
    endtask

    task automatic testNoneMode();
        wbWrite(RegControl, controlWord(2'd3, 1'b1, 1'b1));
        checkValue(outDac0, dac0Val, "NoneMode outDac0");
        checkValue(outScOrReadreg, 1, "NoneMode outScOrReadreg");
        checkValue(usbStartStop, 1, "NoneMode usbStartStop");
        checkValue(microrocAcqStartStop, 1, "NoneMode microrocAcqStartStop");
        clearStreams();
        driveAsicWords(6);
        checkStreams("NoneMode data path");
        wbWrite(RegControl, controlWord(2'd0, 1'b0, 1'b0));
    endtask

    initial begin
        rstN              = 1'b0;
        wbAdr             = '0;
        wbDatI            = '0;
        wbWe              = 1'b0;
        wbStb             = 1'b0;
        wbCyc             = 1'b0;
        trigger           = 1'b0;
        microrocAcqData   = '0;
        microrocAcqDataEn = 1'b0;
        usbFifoFull       = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rstN = 1'b1;
        testRegisters();
        testAcqPath();
        testSCurve();
        testBackPressure();
        testSweepAcq();
        testNoneMode();
        $display("Finished after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
